// ==== build.f ====
source/ghash_pkg.sv
source/gf128_mult.sv
source/ghash_block_select.sv
source/ghash_accumulator.sv
source/gcm_tag_top.sv
sim/gcm_tag_sva.sv
sim/gcm_tag_checker.sv
sim/tb_gcm_tag.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_gcm_tag \
		-f build.f -Mdir obj_dir -o sim_gcm_tag

# Pass only if the testbench printed its pass message
run: compile
	@out="$$(./obj_dir/sim_gcm_tag +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// ==== sim/tb_gcm_tag.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gcm_tag
    import ghash_pkg::*;
();

    localparam int NUM_ENTRIES = 8;
    localparam int TAG_TIMEOUT = 100;

    logic       clk;
    logic       arst_n;
    logic       new_instance;
    gcm_block_t h;
    gcm_block_t ek_j0;
    gcm_block_t aad;
    gcm_block_t cipher_text;
    gcm_len_t   aad_size;
    gcm_len_t   text_size;
    gcm_block_t tag;
    logic       tag_ready;

    int checker_errors;
    int tag_count;
    int pending;
    int tb_errors;
    int total_errors;
    int sva_fails;

    // Per instance: AAD blocks, text blocks, H, E(K,J0), restart mid-instance
    int         tbl_aad_blocks  [NUM_ENTRIES] = '{2, 0, 1, 3, 2, 0, 1, 4};
    int         tbl_text_blocks [NUM_ENTRIES] = '{0, 3, 1, 2, 4, 0, 2, 1};
    logic       tbl_restart     [NUM_ENTRIES] = '{0, 0, 0, 0, 1, 0, 0, 1};
    gcm_block_t tbl_h           [NUM_ENTRIES] = '{
        128'h66e94bd4_ef8a2c3b_884cfa59_ca342b2e,
        128'hb83b5337_08bf535d_0aa6e529_80d53b78,
        128'h466923ec_9ae68254_4bd5de43_3a1a4d5b,
        128'hacbef205_79b4b8eb_ce889bac_8732dad7,
        128'h9e2c0b41_75d8a3f6_0c1e4b27_d3a95f80,
        128'h01234567_89abcdef_fedcba98_76543210,
        128'h00000000_00000000_00000000_00000000,
        128'h80000000_00000000_00000000_00000001
    };
    gcm_block_t tbl_ek          [NUM_ENTRIES] = '{
        128'h58e2fcce_fa7e3061_367f1d57_a4e7455a,
        128'h3247184b_3c4f69a4_4dbcd228_87bbb418,
        128'hcd33b28a_c773f74b_a00ed1f3_12572435,
        128'h0fa1b7e3_44d2c9a8_6b5f3e01_92c7d4aa,
        128'h7d1e9c35_b0a4f862_19e7c5d3_4a8b6f20,
        128'hffffffff_00000000_ffffffff_00000000,
        128'hc0ffee00_5a5a5a5a_a5a5a5a5_00c0ffee,
        128'h13579bdf_2468ace0_fdb97531_0eca8642
    };

    gcm_tag_top i_gcm_tag_top
    (
        .clk            (clk),
        .i_arst_n       (arst_n),
        .i_new_instance (new_instance),
        .i_h            (h),
        .i_ek_j0        (ek_j0),
        .i_aad          (aad),
        .i_cipher_text  (cipher_text),
        .i_aad_size     (aad_size),
        .i_text_size    (text_size),
        .o_tag          (tag),
        .o_tag_ready    (tag_ready)
    );

    gcm_tag_checker i_gcm_tag_checker
    (
        .clk            (clk),
        .i_arst_n       (arst_n),
        .i_new_instance (new_instance),
        .i_h            (h),
        .i_ek_j0        (ek_j0),
        .i_aad          (aad),
        .i_cipher_text  (cipher_text),
        .i_aad_size     (aad_size),
        .i_text_size    (text_size),
        .i_tag          (tag),
        .i_tag_ready    (tag_ready),
        .o_error_count  (checker_errors),
        .o_tag_count    (tag_count),
        .o_pending      (pending)
    );

    bind ghash_accumulator gcm_tag_sva i_gcm_tag_sva
    (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_absorb    (i_absorb),
        .i_first     (i_first),
        .i_last      (i_last),
        .o_tag_ready (o_tag_ready),
        .s_q         (s_q)
    );

    always #10 clk = ~clk;

    function automatic gcm_block_t random_block();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // One slot per clock, keys and sizes scrambled outside slot 0
    task automatic drive_slot(input logic pulse, input gcm_len_t asz, input gcm_len_t tsz,
                              input gcm_block_t hv, input gcm_block_t ekv);
        @(posedge clk);
        #1;
        new_instance = pulse;
        aad          = random_block();
        cipher_text  = random_block();
        if (pulse)
        begin
            h         = hv;
            ek_j0     = ekv;
            aad_size  = asz;
            text_size = tsz;
        end
        else
        begin
            h         = random_block();
            ek_j0     = random_block();
            aad_size  = {$urandom, $urandom};
            text_size = {$urandom, $urandom};
        end
    endtask

    task automatic run_instance(input int idx);
        gcm_len_t asz;
        gcm_len_t tsz;
        int       total;
        asz   = gcm_len_t'(tbl_aad_blocks[idx]) << BLOCK_SHIFT;
        tsz   = gcm_len_t'(tbl_text_blocks[idx]) << BLOCK_SHIFT;
        total = tbl_aad_blocks[idx] + tbl_text_blocks[idx];
        drive_slot(1'b1, asz, tsz, tbl_h[idx], tbl_ek[idx]);
        // Abandon the first attempt after one data slot
        if (tbl_restart[idx])
        begin
            drive_slot(1'b0, asz, tsz, tbl_h[idx], tbl_ek[idx]);
            drive_slot(1'b1, asz, tsz, tbl_h[idx], tbl_ek[idx]);
        end
        for (int s = 1; s <= total; s++)
        begin
            drive_slot(1'b0, asz, tsz, tbl_h[idx], tbl_ek[idx]);
        end
        // Drop the strobe so a zero-length instance is not repeated
        drive_slot(1'b0, asz, tsz, tbl_h[idx], tbl_ek[idx]);
    endtask

    task automatic wait_for_tag(input int idx);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!tag_ready && cycles < TAG_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!tag_ready)
        begin
            $display("Timeout: instance %0d produced no tag within %0d cycles", idx, TAG_TIMEOUT);
            tb_errors++;
        end
    endtask

    initial
    begin
        void'($urandom(32'h00ffff41));
        clk          = 1'b0;
        arst_n       = 1'b0;
        new_instance = 1'b0;
        h            = '0;
        ek_j0        = '0;
        aad          = '0;
        cipher_text  = '0;
        aad_size     = '0;
        text_size    = '0;
        tb_errors    = 0;

        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Idle slots must be ignored
        repeat (3) drive_slot(1'b0, '0, '0, '0, '0);

        for (int idx = 0; idx < NUM_ENTRIES; idx++)
        begin
            run_instance(idx);
            wait_for_tag(idx);
        end

        repeat (4) drive_slot(1'b0, '0, '0, '0, '0);
        @(negedge clk);

        if (tag_count != NUM_ENTRIES)
        begin
            $display("Expected %0d tags but the DUT delivered %0d", NUM_ENTRIES, tag_count);
            tb_errors++;
        end
        if (pending != 0)
        begin
            $display("%0d expected tags never appeared", pending);
            tb_errors++;
        end

        sva_fails    = int'(i_gcm_tag_top.i_ghash_accumulator.i_gcm_tag_sva.fail_count);
        total_errors = checker_errors + tb_errors + sva_fails;
        $display("Tags %0d, checker errors %0d, testbench errors %0d, assertion failures %0d",
                 tag_count, checker_errors, tb_errors, sva_fails);
        if (total_errors == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/gcm_tag_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module gcm_tag_checker
    import ghash_pkg::*;
(
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_new_instance,
    input  gcm_block_t i_h,
    input  gcm_block_t i_ek_j0,
    input  gcm_block_t i_aad,
    input  gcm_block_t i_cipher_text,
    input  gcm_len_t   i_aad_size,
    input  gcm_len_t   i_text_size,
    input  gcm_block_t i_tag,
    input  logic       i_tag_ready,
    output int         o_error_count,
    output int         o_tag_count,
    output int         o_pending
);

    // Reference GHASH state, one instance at a time
    logic       active;
    int         slot;
    int         a_cnt;
    int         c_cnt;
    gcm_len_t   aad_sz;
    gcm_len_t   txt_sz;
    gcm_block_t h_ref;
    gcm_block_t ek_ref;
    gcm_block_t s_ref;
    gcm_block_t exp_q [$];

    // Polynomial product, then reduction by x^128 = x^7 + x^2 + x + 1
    function automatic gcm_block_t gf_multiply(input gcm_block_t a, input gcm_block_t b);
        logic [2*BLOCK_BITS-2:0] prod;
        logic [2*BLOCK_BITS-2:0] b_wide;
        gcm_block_t              res;
        prod   = '0;
        b_wide = '0;
        // Block index k holds the coefficient of x^k
        for (int k = 0; k < BLOCK_BITS; k++)
        begin
            b_wide[k] = b[k];
        end
        for (int i = 0; i < BLOCK_BITS; i++)
        begin
            if (a[i])
            begin
                prod = prod ^ (b_wide << i);
            end
        end
        for (int d = 2*BLOCK_BITS-2; d >= BLOCK_BITS; d--)
        begin
            if (prod[d])
            begin
                prod[d]     = 1'b0;
                prod[d-121] = prod[d-121] ^ 1'b1;
                prod[d-126] = prod[d-126] ^ 1'b1;
                prod[d-127] = prod[d-127] ^ 1'b1;
                prod[d-128] = prod[d-128] ^ 1'b1;
            end
        end
        for (int k = 0; k < BLOCK_BITS; k++)
        begin
            res[k] = prod[k];
        end
        return res;
    endfunction

    initial
    begin
        active        = 1'b0;
        slot          = 0;
        o_error_count = 0;
        o_tag_count   = 0;
        o_pending     = 0;
    end

    // Inputs and outputs are both settled at the falling edge
    always @(negedge clk)
    begin
        gcm_block_t blk;
        gcm_block_t exp_tag;
        if (!i_arst_n)
        begin
            active = 1'b0;
            exp_q.delete();
        end
        else
        begin
            if (i_new_instance)
            begin
                active = 1'b1;
                slot   = 0;
                s_ref  = '0;
                h_ref  = i_h;
                ek_ref = i_ek_j0;
                aad_sz = i_aad_size;
                txt_sz = i_text_size;
                a_cnt  = int'(aad_sz >> BLOCK_SHIFT);
                c_cnt  = int'(txt_sz >> BLOCK_SHIFT);
            end
            if (active)
            begin
                if (slot < a_cnt)
                begin
                    blk = i_aad;
                end
                else if (slot < a_cnt + c_cnt)
                begin
                    blk = i_cipher_text;
                end
                else
                begin
                    blk = {aad_sz, txt_sz};
                end
                s_ref = gf_multiply(s_ref ^ blk, h_ref);
                if (slot == a_cnt + c_cnt)
                begin
                    exp_q.push_back(s_ref ^ ek_ref);
                    active = 1'b0;
                end
                slot++;
            end
            if (i_tag_ready)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("o_tag_ready pulsed although no instance had completed");
                    o_error_count++;
                end
                else
                begin
                    exp_tag = exp_q.pop_front();
                    o_tag_count++;
                    if (i_tag !== exp_tag)
                    begin
                        $display("FAIL o_tag: got %h, expected %h", i_tag, exp_tag);
                        o_error_count++;
                    end
                end
            end
        end
        o_pending = exp_q.size();
    end

endmodule

`default_nettype wire

// ==== sim/gcm_tag_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module gcm_tag_sva
    import ghash_pkg::*;
(
    input logic       clk,
    input logic       i_arst_n,
    input logic       i_absorb,
    input logic       i_first,
    input logic       i_last,
    input logic       o_tag_ready,
    input gcm_block_t s_q
);

    int unsigned fail_count = 0;

    // Nothing is absorbed after the length slot until a new instance starts
    a_idle_after_last: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_absorb && i_last) |=> (!i_absorb || i_first))
    else
    begin
        $error("block absorbed after the length slot without a new instance");
        fail_count++;
    end

    // Two pulses in a row only when a new instance came in between
    a_single_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_tag_ready |=> (!o_tag_ready || $past(i_first)))
    else
    begin
        $error("o_tag_ready held high without a new instance");
        fail_count++;
    end

    // Clean state when reset is released
    a_reset_state: assert property (@(posedge clk)
        $rose(i_arst_n) |-> (!o_tag_ready && !i_absorb && (s_q == '0)))
    else
    begin
        $error("accumulator not cleared by reset");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== source/gcm_tag_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gcm_tag_top
    import ghash_pkg::*;
(
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_new_instance,
    input  gcm_block_t i_h,
    input  gcm_block_t i_ek_j0,
    input  gcm_block_t i_aad,
    input  gcm_block_t i_cipher_text,
    input  gcm_len_t   i_aad_size,
    input  gcm_len_t   i_text_size,
    output gcm_block_t o_tag,
    output logic       o_tag_ready
);

    logic       r_new_instance;
    gcm_block_t r_h;
    gcm_block_t r_ek_j0;
    gcm_block_t r_aad;
    gcm_block_t r_cipher_text;
    gcm_len_t   r_aad_size;
    gcm_len_t   r_text_size;

    gcm_block_t sel_block;
    logic       sel_absorb;
    logic       sel_first;
    logic       sel_last;

    // Input stage, the strobe is the only control bit
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_new_instance <= 1'b0;
        end
        else
        begin
            r_new_instance <= i_new_instance;
        end
    end

    always_ff @(posedge clk)
    begin
        r_h           <= i_h;
        r_ek_j0       <= i_ek_j0;
        r_aad         <= i_aad;
        r_cipher_text <= i_cipher_text;
        r_aad_size    <= i_aad_size;
        r_text_size   <= i_text_size;
    end

    ghash_block_select i_ghash_block_select
    (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_new_instance (r_new_instance),
        .i_aad          (r_aad),
        .i_cipher_text  (r_cipher_text),
        .i_aad_size     (r_aad_size),
        .i_text_size    (r_text_size),
        .o_block        (sel_block),
        .o_absorb       (sel_absorb),
        .o_first        (sel_first),
        .o_last         (sel_last)
    );

    ghash_accumulator i_ghash_accumulator
    (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_block     (sel_block),
        .i_absorb    (sel_absorb),
        .i_first     (sel_first),
        .i_last      (sel_last),
        .i_h         (r_h),
        .i_ek_j0     (r_ek_j0),
        .o_tag       (o_tag),
        .o_tag_ready (o_tag_ready)
    );

endmodule

`default_nettype wire

// ==== source/ghash_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module ghash_accumulator
    import ghash_pkg::*;
(
    input  logic       clk,
    input  logic       i_arst_n,
    input  gcm_block_t i_block,
    input  logic       i_absorb,
    input  logic       i_first,
    input  logic       i_last,
    input  gcm_block_t i_h,
    input  gcm_block_t i_ek_j0,
    output gcm_block_t o_tag,
    output logic       o_tag_ready
);

    gcm_block_t s_q;
    gcm_block_t h_q;
    gcm_block_t ek_j0_q;

    gcm_block_t cur_h;
    gcm_block_t cur_ek_j0;
    gcm_block_t mult_in;
    gcm_block_t s_next;

    // Keys are taken from the inputs on the first slot, before they are held
    assign cur_h     = i_first ? i_h : h_q;
    assign cur_ek_j0 = i_first ? i_ek_j0 : ek_j0_q;

    // S starts from zero on the first slot
    assign mult_in = (i_first ? '0 : s_q) ^ i_block;

    gf128_mult i_gf128_mult
    (
        .i_x (mult_in),
        .i_y (cur_h),
        .o_z (s_next)
    );

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            s_q         <= '0;
            o_tag_ready <= 1'b0;
        end
        else
        begin
            o_tag_ready <= i_absorb && i_last;
            if (i_absorb)
            begin
                s_q <= s_next;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_first)
        begin
            h_q     <= i_h;
            ek_j0_q <= i_ek_j0;
        end
        // Tag holds until the next instance completes
        if (i_absorb && i_last)
        begin
            o_tag <= s_next ^ cur_ek_j0;
        end
    end

endmodule

`default_nettype wire

// ==== source/ghash_block_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module ghash_block_select
    import ghash_pkg::*;
(
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_new_instance,
    input  gcm_block_t i_aad,
    input  gcm_block_t i_cipher_text,
    input  gcm_len_t   i_aad_size,
    input  gcm_len_t   i_text_size,
    output gcm_block_t o_block,
    output logic       o_absorb,
    output logic       o_first,
    output logic       o_last
);

    absorb_state_t state_q;
    blk_cnt_t      slot_q;
    gcm_len_t      aad_size_q;
    gcm_len_t      text_size_q;

    gcm_len_t cur_aad_size;
    gcm_len_t cur_text_size;
    blk_cnt_t cur_slot;
    blk_cnt_t aad_count;
    blk_cnt_t text_count;
    blk_cnt_t total_count;
    logic     len_slot;

    // On the new-instance slot the sizes come straight from the inputs
    always_comb
    begin
        if (i_new_instance)
        begin
            cur_aad_size  = i_aad_size;
            cur_text_size = i_text_size;
            cur_slot      = '0;
        end
        else
        begin
            cur_aad_size  = aad_size_q;
            cur_text_size = text_size_q;
            cur_slot      = slot_q;
        end
        aad_count   = blk_cnt_t'(cur_aad_size >> BLOCK_SHIFT);
        text_count  = blk_cnt_t'(cur_text_size >> BLOCK_SHIFT);
        total_count = aad_count + text_count;
    end

    assign len_slot = (cur_slot == total_count);
    assign o_absorb = i_new_instance || (state_q == ST_ABSORB);
    assign o_first  = i_new_instance;
    assign o_last   = o_absorb && len_slot;

    // AAD first, then ciphertext, then the length block
    always_comb
    begin
        if (len_slot)
        begin
            o_block = {cur_aad_size, cur_text_size};
        end
        else if (cur_slot < aad_count)
        begin
            o_block = i_aad;
        end
        else
        begin
            o_block = i_cipher_text;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state_q <= ST_IDLE;
            slot_q  <= '0;
        end
        else if (o_absorb)
        begin
            state_q <= o_last ? ST_IDLE : ST_ABSORB;
            slot_q  <= cur_slot + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_new_instance)
        begin
            aad_size_q  <= i_aad_size;
            text_size_q <= i_text_size;
        end
    end

endmodule

`default_nettype wire

// ==== source/gf128_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

module gf128_mult
    import ghash_pkg::*;
(
    input  gcm_block_t i_x,
    input  gcm_block_t i_y,
    output gcm_block_t o_z
);

    gcm_block_t z_acc;
    gcm_block_t v_acc;
    logic       v_lsb;

    // Shift-and-add over all 128 bits of X, MSB first
    always_comb
    begin
        z_acc = '0;
        v_acc = i_y;
        v_lsb = 1'b0;
        for (int idx = 0; idx < BLOCK_BITS; idx++)
        begin
            if (i_x[idx])
            begin
                z_acc = z_acc ^ v_acc;
            end

            // Bit 127 falls off the end on the shift
            v_lsb = v_acc[BLOCK_BITS-1];
            v_acc = v_acc >> 1;
            if (v_lsb)
            begin
                v_acc = v_acc ^ {GF_R_POLY, {(BLOCK_BITS-8){1'b0}}};
            end
        end
    end

    assign o_z = z_acc;

endmodule

`default_nettype wire

// ==== source/ghash_pkg.sv ====
`default_nettype none

package ghash_pkg;

    // GCM block, index 0 is the most significant bit
    localparam int BLOCK_BITS = 128;
    typedef logic [0:BLOCK_BITS-1] gcm_block_t;

    // Bit count of the AAD or the text
    localparam int LEN_BITS = 64;
    typedef logic [LEN_BITS-1:0] gcm_len_t;

    // Sizes are whole blocks, so a shift turns bits into blocks
    localparam int BLOCK_SHIFT = $clog2(BLOCK_BITS);

    // Block counter, one instance holds at most 65535 blocks
    localparam int BLK_CNT_BITS = 16;
    typedef logic [BLK_CNT_BITS-1:0] blk_cnt_t;

    // Reduction pattern for x^128 + x^7 + x^2 + x + 1, applied at the top of V
    localparam logic [7:0] GF_R_POLY = 8'b11100001;

    // Instance state
    typedef enum logic
    {
        ST_IDLE,
        ST_ABSORB
    } absorb_state_t;

endpackage

`default_nettype wire
